//--- build.f
+incdir+source
source/sram_pkg.sv
source/sram_spram.sv
source/sram_arbiter.sv
source/sram_boot_ctrl.sv
source/sram_top.sv
tb/sram_assert.sv
tb/sram_tb.sv

//--- tb/sram_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

module sram_tb;

   import sram_pkg::*;

   localparam int Timeout = 20;
   localparam int Words = 2 ** $bits(waddr_t);

   // one table row, port_d selects the data port
   typedef struct packed {
      logic     port_d;
      mem_req_t req;
      data_t    exp;
   } entry_t;

   logic     clk;
   logic     reset;
   logic     boot_valid;
   data_t    boot_data;
   logic     boot_finished;
   logic     i_valid;
   mem_req_t i_req;
   logic     i_ready;
   data_t    i_rdata;
   logic     i_rvalid;
   logic     d_valid;
   mem_req_t d_req;
   logic     d_ready;
   data_t    d_rdata;
   logic     d_rvalid;

   data_t  ref_mem [Words];   // reference copy of the SRAM
   entry_t table_q [$];

   sram_top dut0 (
      .clk_i        (clk),
      .reset_i      (reset),
      .boot_valid_i (boot_valid),
      .boot_data_i  (boot_data),
      .boot_done_o  (boot_finished),
      .i_valid_i    (i_valid),
      .i_req_i      (i_req),
      .i_ready_o    (i_ready),
      .i_rdata_o    (i_rdata),
      .i_rvalid_o   (i_rvalid),
      .d_valid_i    (d_valid),
      .d_req_i      (d_req),
      .d_ready_o    (d_ready),
      .d_rdata_o    (d_rdata),
      .d_rvalid_o   (d_rvalid)
   );

   bind sram_arbiter sram_assert assert0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .i_valid_i  (i_valid_i),
      .i_req_i    (i_req_i),
      .d_valid_i  (d_valid_i),
      .d_req_i    (d_req_i),
      .d_ready_i  (d_ready_o),
      .i_rvalid_i (i_rvalid_o),
      .d_rvalid_i (d_rvalid_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // a failed bound assertion ends the run at the next falling edge
   always @(negedge clk) begin
      if (dut0.arbiter0.assert0.fail_cnt != 0) begin
         $display("A bound assertion on the arbiter failed before time %0t", $time);
         $display("Test failed");
         $fatal(1, "bound assertion failed");
      end
   end

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("Timed out at time %0t waiting for %s", $time, what);
      $display("Test failed");
      $fatal(1, "wait limit exceeded");
   endtask

   // byte lanes merge independently
   function automatic void ref_write(input mem_req_t req);
      for (int b = 0; b < $bits(wstrb_t); b++) begin
         if (req.wstrb[b]) ref_mem[req.addr][b*8 +: 8] = req.wdata[b*8 +: 8];
      end
   endfunction

   task automatic add_entry(input logic port_d, input int addr, input data_t wdata,
                            input wstrb_t wstrb);
      entry_t e;
      e.port_d = port_d;
      e.req.addr = waddr_t'(addr);
      e.req.wdata = wdata;
      e.req.wstrb = wstrb;
      if (wstrb != '0) ref_write(e.req);
      e.exp = ref_mem[e.req.addr];   // only used for reads
      table_q.push_back(e);
   endtask

   task automatic build_table();
      for (int k = 0; k < `SRAM_BOOT_WORDS; k++) add_entry(1'b0, k, '0, '0);
      // full words first so no byte stays undefined
      for (int k = 0; k < 8; k++) add_entry(1'b1, 64 + k, $urandom, '1);
      for (int k = 0; k < 8; k++) begin
         add_entry(1'b1, 64 + k, $urandom, wstrb_t'(($urandom % 14) + 1));
      end
      add_entry(1'b0, 66, $urandom, wstrb_t'(9));   // partial write from fetch side
      for (int k = 0; k < 8; k++) add_entry(1'b1, 64 + k, '0, '0);
      add_entry(1'b1, 2, '0, '0);
      add_entry(1'b0, 69, '0, '0);
   endtask

   task automatic idle_ports();
      i_valid = 1'b0;
      i_req = '0;
      d_valid = 1'b0;
      d_req = '0;
   endtask

   task automatic drive_entry(input entry_t e);
      idle_ports();
      if (e.port_d) begin
         d_valid = 1'b1;
         d_req = e.req;
      end else begin
         i_valid = 1'b1;
         i_req = e.req;
      end
   endtask

   // called just after a falling edge
   task automatic wait_ready(input logic port_d);
      int cnt;
      cnt = 0;
      #1;
      while (!(port_d ? d_ready : i_ready)) begin
         @(negedge clk);
         #1;
         cnt++;
         if (cnt > Timeout) abort_timeout(port_d ? "d_ready_o" : "i_ready_o");
      end
   endtask

   task automatic wait_boot_done();
      int cnt;
      cnt = 0;
      while (!boot_finished) begin
         @(negedge clk);
         cnt++;
         if (cnt > Timeout) abort_timeout("boot_done_o");
      end
   endtask

   // response of a request accepted on the previous rising edge
   task automatic verify_response(input entry_t e);
      logic rd;
      rd = ~(|e.req.wstrb);
      check_flag(e.port_d ? "d_rvalid_o" : "i_rvalid_o", e.port_d ? d_rvalid : i_rvalid, rd);
      check_flag(e.port_d ? "i_rvalid_o" : "d_rvalid_o", e.port_d ? i_rvalid : d_rvalid, 1'b0);
      if (rd) begin
         check_data($sformatf("rdata of word %0d", e.req.addr),
                    e.port_d ? d_rdata : i_rdata, e.exp);
      end
   endtask

   task automatic expect_reset_state();
      check_flag("boot_done_o after reset", boot_finished, 1'b0);
      check_flag("i_rvalid_o after reset", i_rvalid, 1'b0);
      check_flag("d_rvalid_o after reset", d_rvalid, 1'b0);
      check_flag("i_ready_o after reset", i_ready, 1'b0);
   endtask

   task automatic boot_load_image();
      data_t word;
      i_valid = 1'b1;   // fetch held through the whole load
      i_req = '0;
      for (int k = 0; k < `SRAM_BOOT_WORDS; k++) begin
         word = $urandom;
         check_flag("boot_done_o before last word", boot_finished, 1'b0);
         boot_valid = 1'b1;
         boot_data = word;
         ref_mem[k] = word;
         #1;
         check_flag("i_ready_o during boot", i_ready, 1'b0);
         check_flag("i_rvalid_o during boot", i_rvalid, 1'b0);
         @(posedge clk);
         @(negedge clk);
      end
      boot_valid = 1'b0;
      boot_data = '0;
      i_valid = 1'b0;
      wait_boot_done();
      check_flag("i_ready_o after boot", i_ready, 1'b1);
      check_flag("i_rvalid_o after boot", i_rvalid, 1'b0);
   endtask

   // one request per cycle, response checked while the next one goes out
   task automatic run_table();
      entry_t prev;
      logic   pending;
      pending = 1'b0;
      foreach (table_q[n]) begin
         if (pending) verify_response(prev);
         drive_entry(table_q[n]);
         wait_ready(table_q[n].port_d);
         @(posedge clk);
         @(negedge clk);
         prev = table_q[n];
         pending = 1'b1;
      end
      if (pending) verify_response(prev);
      idle_ports();
   endtask

   task automatic same_cycle_reads();
      i_valid = 1'b1;
      i_req = '0;
      i_req.addr = waddr_t'(3);
      d_valid = 1'b1;
      d_req = '0;
      d_req.addr = waddr_t'(64);
      #1;
      check_flag("d_ready_o with both ports valid", d_ready, 1'b0);
      check_flag("i_ready_o with both ports valid", i_ready, 1'b1);
      @(posedge clk);
      @(negedge clk);
      check_flag("i_rvalid_o for first read", i_rvalid, 1'b1);
      check_flag("d_rvalid_o while blocked", d_rvalid, 1'b0);
      check_data("i_rdata_o of word 3", i_rdata, ref_mem[3]);
      i_valid = 1'b0;
      i_req = '0;
      wait_ready(1'b1);   // data read still held
      @(posedge clk);
      @(negedge clk);
      check_flag("d_rvalid_o for delayed read", d_rvalid, 1'b1);
      check_flag("i_rvalid_o after data read", i_rvalid, 1'b0);
      check_data("d_rdata_o of word 64", d_rdata, ref_mem[64]);
      idle_ports();
      @(negedge clk);
      check_flag("i_rvalid_o when idle", i_rvalid, 1'b0);
      check_flag("d_rvalid_o when idle", d_rvalid, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h7c1587b6));
      reset = 1'b1;
      boot_valid = 1'b0;
      boot_data = '0;
      idle_ports();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      expect_reset_state();
      boot_load_image();
      build_table();
      run_table();
      same_cycle_reads();
      if (dut0.arbiter0.assert0.fail_cnt == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1, "bound assertion failed");
      end
   end

endmodule

`default_nettype wire

//--- tb/sram_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sram_assert (
   input  wire logic               clk_i,
   input  wire logic               reset_i,
   input  wire logic               i_valid_i,
   input  wire sram_pkg::mem_req_t i_req_i,
   input  wire logic               d_valid_i,
   input  wire sram_pkg::mem_req_t d_req_i,
   input  wire logic               d_ready_i,
   input  wire logic               i_rvalid_i,
   input  wire logic               d_rvalid_i
);

   import sram_pkg::*;

   logic        i_rd;           // instruction read taken this cycle
   logic        d_rd;           // data read taken this cycle
   int unsigned fail_cnt = 0;   // assertion failures so far

   assign i_rd = i_valid_i & ~(|i_req_i.wstrb);
   assign d_rd = d_valid_i & d_ready_i & ~(|d_req_i.wstrb);

   // instruction side has fixed priority
   a_d_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
      i_valid_i && d_valid_i |=> !d_rvalid_i)
      else begin
         fail_cnt++;
         $error("data request served while instruction side valid");
      end

   a_i_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
      i_rd |=> i_rvalid_i)
      else begin
         fail_cnt++;
         $error("instruction read without rvalid one cycle later");
      end

   // writes and idle cycles give no response
   a_i_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
      !i_rd |=> !i_rvalid_i)
      else begin
         fail_cnt++;
         $error("instruction rvalid without an accepted read");
      end

   a_d_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
      d_rd |=> d_rvalid_i)
      else begin
         fail_cnt++;
         $error("data read without rvalid one cycle later");
      end

   a_d_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
      !d_rd |=> !d_rvalid_i)
      else begin
         fail_cnt++;
         $error("data rvalid without an accepted read");
      end

endmodule

`default_nettype wire

//--- source/sram_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_top (
   input  wire logic               clk_i,
   input  wire logic               reset_i,

   // boot stream
   input  wire logic               boot_valid_i,
   input  wire sram_pkg::data_t    boot_data_i,
   output logic                    boot_done_o,

   // instruction bus
   input  wire logic               i_valid_i,
   input  wire sram_pkg::mem_req_t i_req_i,
   output logic                    i_ready_o,
   output sram_pkg::data_t         i_rdata_o,
   output logic                    i_rvalid_o,

   // data bus
   input  wire logic               d_valid_i,
   input  wire sram_pkg::mem_req_t d_req_i,
   output logic                    d_ready_o,
   output sram_pkg::data_t         d_rdata_o,
   output logic                    d_rvalid_o
);

   import sram_pkg::*;

   logic     arb_i_valid;   // instruction side after boot muxing
   mem_req_t arb_i_req;
   logic     mem_en;
   mem_req_t mem_req;
   data_t    mem_rdata;

   sram_boot_ctrl boot_ctrl0 (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .boot_valid_i  (boot_valid_i),
      .boot_data_i   (boot_data_i),
      .fetch_valid_i (i_valid_i),
      .fetch_req_i   (i_req_i),
      .fetch_ready_o (i_ready_o),
      .boot_done_o   (boot_done_o),
      .i_valid_o     (arb_i_valid),
      .i_req_o       (arb_i_req)
   );

   // instruction ready toward the arbiter is constant, boot ctrl gates it
   sram_arbiter arbiter0 (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .i_valid_i  (arb_i_valid),
      .i_req_i    (arb_i_req),
      .i_ready_o  (),
      .i_rvalid_o (i_rvalid_o),
      .d_valid_i  (d_valid_i),
      .d_req_i    (d_req_i),
      .d_ready_o  (d_ready_o),
      .d_rvalid_o (d_rvalid_o),
      .mem_en_o   (mem_en),
      .mem_req_o  (mem_req)
   );

   sram_spram spram0 (
      .clk_i   (clk_i),
      .req_i   (mem_req),
      .en_i    (mem_en),
      .rdata_o (mem_rdata)
   );

   // both ports watch the same output, rvalid tells whose it is
   assign i_rdata_o = mem_rdata;
   assign d_rdata_o = mem_rdata;

endmodule

`default_nettype wire

//--- source/sram_boot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_params.svh"

module sram_boot_ctrl (
   input  wire logic               clk_i,
   input  wire logic               reset_i,

   // boot word stream, no back-pressure
   input  wire logic               boot_valid_i,
   input  wire sram_pkg::data_t    boot_data_i,

   // fetch requests from the core
   input  wire logic               fetch_valid_i,
   input  wire sram_pkg::mem_req_t fetch_req_i,
   output logic                    fetch_ready_o,
   output logic                    boot_done_o,

   // instruction side toward the arbiter
   output logic                    i_valid_o,
   output sram_pkg::mem_req_t      i_req_o
);

   import sram_pkg::*;

   boot_state_t state;
   waddr_t      boot_cnt;   // next word to load
   logic        last_word;

   assign last_word = (boot_cnt == waddr_t'(`SRAM_BOOT_WORDS - 1));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state    <= boot_load;
         boot_cnt <= '0;
      end else if (state == boot_load && boot_valid_i) begin
         boot_cnt <= boot_cnt + 1'b1;
         if (last_word) begin
            state <= boot_done;   // on the edge taking the final word
         end
      end
   end

   // request path is purely combinational
   always_comb begin
      i_req_o = fetch_req_i;
      i_valid_o = fetch_valid_i;
      fetch_ready_o = 1'b1;
      if (state == boot_load) begin
         // full word write, fetches held off
         i_valid_o = boot_valid_i;
         i_req_o.addr = boot_cnt;
         i_req_o.wdata = boot_data_i;
         i_req_o.wstrb = '1;
         fetch_ready_o = 1'b0;
      end
   end

   assign boot_done_o = (state == boot_done);

endmodule

`default_nettype wire

//--- source/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
   input  wire logic               clk_i,
   input  wire logic               reset_i,

   // instruction port, always wins
   input  wire logic               i_valid_i,
   input  wire sram_pkg::mem_req_t i_req_i,
   output logic                    i_ready_o,
   output logic                    i_rvalid_o,

   // data port
   input  wire logic               d_valid_i,
   input  wire sram_pkg::mem_req_t d_req_i,
   output logic                    d_ready_o,
   output logic                    d_rvalid_o,

   // toward the memory
   output logic                    mem_en_o,
   output sram_pkg::mem_req_t      mem_req_o
);

   import sram_pkg::*;

   logic d_accept;    // data request taken this cycle
   logic i_rd_nxt;
   logic d_rd_nxt;

   assign i_ready_o = 1'b1;         // memory takes a request every cycle
   assign d_ready_o = ~i_valid_i;   // blocked while the instruction side is busy

   assign d_accept = d_valid_i & ~i_valid_i;

   // fixed priority select
   always_comb begin
      if (i_valid_i) begin
         mem_req_o = i_req_i;
      end else begin
         mem_req_o = d_req_i;
      end
   end

   assign mem_en_o = i_valid_i | d_valid_i;

   // only reads get a response
   assign i_rd_nxt = i_valid_i & is_read(i_req_i);
   assign d_rd_nxt = d_accept & is_read(d_req_i);

   // lines up with the registered memory output
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         i_rvalid_o <= 1'b0;
         d_rvalid_o <= 1'b0;
      end else begin
         i_rvalid_o <= i_rd_nxt;
         d_rvalid_o <= d_rd_nxt;
      end
   end

endmodule

`default_nettype wire

//--- source/sram_spram.sv
`timescale 1ns/1ps
`default_nettype none

module sram_spram (
   input  wire logic               clk_i,
   input  wire sram_pkg::mem_req_t req_i,
   input  wire logic               en_i,
   output sram_pkg::data_t         rdata_o
);

   import sram_pkg::*;

   localparam int Depth = 2 ** $bits(waddr_t);
   localparam int NumBytes = $bits(wstrb_t);

   data_t mem [Depth];

   // byte lanes written independently
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         for (int b = 0; b < NumBytes; b++) begin
            if (req_i.wstrb[b]) begin
               mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   // read every enabled cycle, old word on a write
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         rdata_o <= mem[req_i.addr];
      end
   end

endmodule

`default_nettype wire

//--- source/sram_pkg.sv
`default_nettype none

package sram_pkg;

`include "sram_params.svh"

   // one bus word
   typedef logic [`SRAM_DATA_W-1:0] data_t;

   // word address, byte offset dropped
   typedef logic [`SRAM_ADDR_W-3:0] waddr_t;

   // one strobe per byte lane
   typedef logic [`SRAM_DATA_W/8-1:0] wstrb_t;

   // request as seen by the memory
   typedef struct packed {
      waddr_t addr;
      data_t  wdata;
      wstrb_t wstrb;  // all zero means read
   } mem_req_t;

   typedef enum logic {
      boot_load,
      boot_done
   } boot_state_t;

   // a request without strobes is a read
   function automatic logic is_read(mem_req_t req);
      return ~(|req.wstrb);
   endfunction

endpackage

`default_nettype wire

//--- source/sram_params.svh
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// word width in bits
`define SRAM_DATA_W 32

// byte address width, word address is two bits shorter
`define SRAM_ADDR_W 12

// words written by the boot loader before fetches open up
`define SRAM_BOOT_WORDS 16

`endif
